/* src/cart_pkg.sv */
// Shared sizes, download offsets, header-mode codes and size-field addresses
package cart_pkg;

	// ============================================================
	// Download port
	// ============================================================

	localparam int dl_addr_bits = 25;
	localparam int dl_data_bits = 16;

	// Download index reserved for cheat code files
	localparam logic [7:0] code_index = 8'hFF;

	// Cartridge images carry a 512-byte copier header in front
	localparam logic [dl_addr_bits-1:0] copier_offset = 25'h200;

	// ============================================================
	// Save RAM and masks
	// ============================================================

	// 128 KB of battery-backed RAM
	localparam int bsram_bits = 17;
	localparam int mask_bits = 24;

	// 256 words of 16 bits per 512-byte sector
	localparam int sector_word_bits = 8;

	// ============================================================
	// Header decode
	// ============================================================

	localparam logic [2:0] hdr_auto = 3'd0;
	localparam logic [2:0] hdr_none = 3'd1;
	localparam logic [2:0] hdr_lorom = 3'd2;
	localparam logic [2:0] hdr_hirom = 3'd3;
	localparam logic [2:0] hdr_exhirom = 3'd4;

	// Word holding the ROM size byte; RAM size sits two bytes higher
	localparam logic [dl_addr_bits-1:0] lorom_size_addr = 25'h7FD6 + copier_offset;
	localparam logic [dl_addr_bits-1:0] hirom_size_addr = 25'hFFD6 + copier_offset;
	localparam logic [dl_addr_bits-1:0] exhirom_size_addr = 25'h40FFD6 + copier_offset;

	// 4 MB when the header says nothing
	localparam logic [3:0] default_rom_size = 4'hC;

	// Strobe bit on top of flags, address, compare and replace
	localparam int code_word_bits = 129;

endpackage

/* src/rom_header_detect.sv */
// Cartridge header decoder producing ROM type, region and ROM/RAM address masks
module rom_header_detect (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 cart_download,
	input  logic                                 ioctl_wr,
	input  logic [cart_pkg::dl_addr_bits-1:0]    ioctl_addr,
	input  logic [cart_pkg::dl_data_bits-1:0]    ioctl_dout,
	input  logic [2:0]                           header_mode,
	output logic [7:0]                           rom_type,
	output logic [cart_pkg::mask_bits-1:0]       rom_mask,
	output logic [cart_pkg::mask_bits-1:0]       ram_mask,
	output logic                                 rom_region
);
	import cart_pkg::*;

	logic [3:0]              rom_size;
	logic [3:0]              ram_size;
	logic                    size_upd;
	logic                    hdr_wr;
	logic                    size_force;
	logic [dl_addr_bits-1:0] size_addr;

	// Size code n means 1 KB << n
	function automatic logic [mask_bits-1:0] size_to_mask(input logic [3:0] size);
		logic [mask_bits-1:0] one_kb;
		one_kb = mask_bits'(1024);
		return (one_kb << size) - 1'b1;
	endfunction

	assign hdr_wr = cart_download & ioctl_wr;

	// Forced mappings read the sizes from the internal header
	always_comb begin
		size_force = 1'b1;
		size_addr = lorom_size_addr;
		case (header_mode)
			hdr_lorom:   size_addr = lorom_size_addr;
			hdr_hirom:   size_addr = hirom_size_addr;
			hdr_exhirom: size_addr = exhirom_size_addr;
			default:     size_force = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_type <= 8'd0;
			rom_region <= 1'b0;
			rom_size <= 4'd0;
			ram_size <= 4'd0;
			size_upd <= 1'b0;
		end else begin
			size_upd <= 1'b0;
			if (hdr_wr) begin
				if (ioctl_addr == '0) begin
					size_upd <= 1'b1;
					if (header_mode == hdr_auto && ioctl_dout[7:0] != 8'd0) begin
						{ram_size, rom_size} <= ioctl_dout[7:0];
					end else begin
						rom_size <= default_rom_size;
						ram_size <= 4'd0;
					end
					case (header_mode)
						hdr_none, hdr_lorom: rom_type <= 8'd0;
						hdr_hirom:           rom_type <= 8'd1;
						hdr_exhirom:         rom_type <= 8'd2;
						default:             rom_type <= ioctl_dout[15:8];
					endcase
				end
				if (ioctl_addr == dl_addr_bits'(2)) begin
					rom_region <= ioctl_dout[8];
				end
				// Later writes override the sizes from word 0
				if (size_force && ioctl_addr == size_addr) begin
					rom_size <= ioctl_dout[11:8];
					size_upd <= 1'b1;
				end
				if (size_force && ioctl_addr == size_addr + 2'd2) begin
					ram_size <= ioctl_dout[3:0];
					size_upd <= 1'b1;
				end
			end
		end
	end

	// Masks follow one cycle behind a size update
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_mask <= '0;
			ram_mask <= '0;
		end else if (size_upd) begin
			rom_mask <= size_to_mask(rom_size);
			ram_mask <= (ram_size != 4'd0) ? size_to_mask(ram_size) : '0;
		end
	end

endmodule

/* src/cheat_code_collector.sv */
// Cheat code word assembler with one-cycle load strobe and code list reset
module cheat_code_collector (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 code_download,
	input  logic                                 cart_download,
	input  logic                                 ioctl_wr,
	input  logic [cart_pkg::dl_addr_bits-1:0]    ioctl_addr,
	input  logic [cart_pkg::dl_data_bits-1:0]    ioctl_dout,
	output logic [cart_pkg::code_word_bits-1:0] gg_code,
	output logic                                 gg_reset
);
	import cart_pkg::*;

	logic [dl_addr_bits-1:0]   code_offset;
	logic [code_word_bits-2:0] code_payload;
	logic                      code_strobe;
	logic                      code_wr;

	// Code files share the copier header offset of the cartridge images
	assign code_offset = ioctl_addr - copier_offset;
	assign code_wr = code_download & ioctl_wr;

	// Fields are {flags, address, compare, replace}, low word first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (code_offset[3:0])
				4'd0:  code_payload[111:96] <= ioctl_dout;
				4'd2:  code_payload[127:112] <= ioctl_dout;
				4'd4:  code_payload[79:64] <= ioctl_dout;
				4'd6:  code_payload[95:80] <= ioctl_dout;
				4'd8:  code_payload[47:32] <= ioctl_dout;
				4'd10: code_payload[63:48] <= ioctl_dout;
				4'd12: code_payload[15:0] <= ioctl_dout;
				4'd14: code_payload[31:16] <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last word of a code clocks it into the cheat engine
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			code_strobe <= 1'b0;
		end else begin
			code_strobe <= code_wr && code_offset[3:0] == 4'd14;
		end
	end

	assign gg_code = {code_strobe, code_payload};

	// Code list is flushed by a new cartridge or a new code file
	assign gg_reset = cart_download | (code_wr & (ioctl_addr == '0));

endmodule

/* src/backup_ram.sv */
// Battery-backed save RAM with byte port for the core and sector word port
module backup_ram (
	input  logic                                       clk_sys,
	input  logic                                       cart_download,
	input  logic                                       ioctl_wr,
	input  logic [cart_pkg::dl_addr_bits-1:0]          ioctl_addr,
	input  logic [19:0]                                bsram_addr,
	input  logic [7:0]                                 bsram_d,
	input  logic                                       bsram_ce_n,
	input  logic                                       bsram_we_n,
	input  logic [cart_pkg::bsram_bits-cart_pkg::sector_word_bits-2:0] sd_lba_low,
	input  logic                                       sd_ack,
	input  logic [cart_pkg::sector_word_bits-1:0]      sd_buff_addr,
	input  logic [cart_pkg::dl_data_bits-1:0]          sd_buff_dout,
	input  logic                                       sd_buff_wr,
	output logic [7:0]                                 bsram_q,
	output logic [cart_pkg::dl_data_bits-1:0]          sd_buff_din
);
	import cart_pkg::*;

	localparam int word_bits = bsram_bits - 1;

	logic [bsram_bits-1:0] a_addr;
	logic [7:0]            a_data;
	logic                  a_we;
	logic                  a_hi_q;
	logic [word_bits-1:0]  b_addr;
	logic                  b_we;

	// Download overwrites the RAM with the low address byte
	assign a_addr = cart_download ? ioctl_addr[bsram_bits-1:0] : bsram_addr[bsram_bits-1:0];
	assign a_data = cart_download ? ioctl_addr[7:0] : bsram_d;
	assign a_we = cart_download ? ioctl_wr : (~bsram_ce_n & ~bsram_we_n);

	assign b_addr = {sd_lba_low, sd_buff_addr};
	assign b_we = sd_buff_wr & sd_ack;

	// Two byte lanes, even bytes in lane 0
	for (genvar lane = 0; lane < 2; lane++) begin : g_lane
		logic [7:0] mem [0:2**word_bits-1];
		logic [7:0] a_q;
		logic [7:0] b_q;

		always_ff @(posedge clk_sys) begin
			if (a_we && a_addr[0] == lane[0]) begin
				mem[a_addr[bsram_bits-1:1]] <= a_data;
			end
			if (b_we) begin
				mem[b_addr] <= sd_buff_dout[lane*8 +: 8];
			end
			a_q <= mem[a_addr[bsram_bits-1:1]];
			b_q <= mem[b_addr];
		end
	end

	// Lane select follows the read data by one cycle
	always_ff @(posedge clk_sys) begin
		a_hi_q <= a_addr[0];
	end

	assign bsram_q = a_hi_q ? g_lane[1].a_q : g_lane[0].a_q;
	assign sd_buff_din = {g_lane[1].b_q, g_lane[0].b_q};

endmodule

/* src/backup_sequencer.sv */
// Save RAM backup control with enable, pending writes and sector transfer FSM
module backup_sequencer (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              cart_download,
	input  logic [cart_pkg::mask_bits-1:0]    ram_mask,
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic                              img_size_nonzero,
	input  logic                              bk_load_req,
	input  logic                              bk_save_req,
	input  logic                              autosave,
	input  logic                              osd_status,
	input  logic                              bsram_ce_n,
	input  logic                              bsram_we_n,
	input  logic                              sd_ack,
	output logic [31:0]                       sd_lba,
	output logic                              sd_rd,
	output logic                              sd_wr,
	output logic                              loading,
	output logic                              pending
);
	import cart_pkg::*;

	logic        bk_ena;
	logic        busy;
	logic        download_q;
	logic        load_req_q;
	logic        save_want_q;
	logic        ack_q;
	logic        core_write;
	logic        save_want;
	logic        load_start;
	logic        save_start;
	logic        auto_load;
	logic        start;
	logic [31:0] last_lba;

	assign core_write = ~bsram_ce_n & ~bsram_we_n;

	// Menu closing with unsaved data counts as a save request
	assign save_want = bk_save_req | (pending & osd_status & autosave);

	assign load_start = bk_load_req & ~load_req_q;
	assign save_start = save_want & ~save_want_q;
	assign auto_load = download_q & ~cart_download & img_size_nonzero;
	assign start = bk_ena & ~busy & (load_start | save_start | auto_load);

	// One sector per 512 bytes of RAM
	assign last_lba = 32'(ram_mask[mask_bits-1:9]);

	// ============================================================
	// Enable and pending tracking
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_ena <= 1'b0;
			pending <= 1'b0;
			download_q <= 1'b0;
		end else begin
			download_q <= cart_download;
			if (cart_download & ~download_q) begin
				bk_ena <= 1'b0;
			end
			// Image is mounted by the time the download finishes
			if (cart_download && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end
			if (bk_ena && !osd_status && core_write) begin
				pending <= 1'b1;
			end else if (busy) begin
				pending <= 1'b0;
			end
		end
	end

	// ============================================================
	// Sector transfer
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			sd_lba <= 32'd0;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
			busy <= 1'b0;
			loading <= 1'b0;
			load_req_q <= 1'b0;
			save_want_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			load_req_q <= bk_load_req;
			save_want_q <= save_want;
			ack_q <= sd_ack;

			// Host took the request
			if (sd_ack & ~ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (start) begin
				busy <= 1'b1;
				loading <= load_start | auto_load;
				sd_lba <= 32'd0;
				sd_rd <= load_start | auto_load;
				sd_wr <= ~(load_start | auto_load);
			end else if (busy && ack_q && !sd_ack) begin
				if (sd_lba >= last_lba) begin
					busy <= 1'b0;
					loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd <= loading;
					sd_wr <= ~loading;
				end
			end
		end
	end

endmodule

/* src/cart_loader_top.sv */
// Cartridge support top level with download decode, status outputs and block wiring
module cart_loader_top (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 ioctl_download,
	input  logic [7:0]                           ioctl_index,
	input  logic [cart_pkg::dl_addr_bits-1:0]    ioctl_addr,
	input  logic [cart_pkg::dl_data_bits-1:0]    ioctl_dout,
	input  logic                                 ioctl_wr,
	input  logic [2:0]                           header_mode,
	input  logic                                 autosave,
	input  logic                                 bk_load_req,
	input  logic                                 bk_save_req,
	input  logic                                 osd_status,
	input  logic                                 img_mounted,
	input  logic                                 img_readonly,
	input  logic                                 img_size_nonzero,
	input  logic                                 sd_ack,
	input  logic [cart_pkg::sector_word_bits-1:0] sd_buff_addr,
	input  logic [cart_pkg::dl_data_bits-1:0]    sd_buff_dout,
	input  logic                                 sd_buff_wr,
	input  logic [19:0]                          bsram_addr,
	input  logic [7:0]                           bsram_d,
	input  logic                                 bsram_ce_n,
	input  logic                                 bsram_we_n,
	output logic [7:0]                           rom_type,
	output logic [cart_pkg::mask_bits-1:0]       rom_mask,
	output logic [cart_pkg::mask_bits-1:0]       ram_mask,
	output logic                                 rom_region,
	output logic [cart_pkg::code_word_bits-1:0]  gg_code,
	output logic                                 gg_reset,
	output logic [31:0]                          sd_lba,
	output logic                                 sd_rd,
	output logic                                 sd_wr,
	output logic [cart_pkg::dl_data_bits-1:0]    sd_buff_din,
	output logic [7:0]                           bsram_q,
	output logic                                 core_hold,
	output logic                                 led_user
);
	import cart_pkg::*;

	logic code_download;
	logic cart_download;
	logic cart_wr;
	logic code_wr;
	logic loading;
	logic pending;

	// Cheat files use their own index, everything else is a cartridge
	assign code_download = ioctl_download & (ioctl_index == code_index);
	assign cart_download = ioctl_download & (ioctl_index != code_index);

	// Address and data are only sampled on a qualified write
	assign cart_wr = ioctl_wr & cart_download;
	assign code_wr = ioctl_wr & code_download;

	// Core stays stopped while the cartridge or its save data streams in
	assign core_hold = cart_download | loading;
	assign led_user = cart_download | (autosave & pending);

	rom_header_detect u_header (
		.clk_sys(clk_sys), .reset(reset), .cart_download(cart_download),
		.ioctl_wr(cart_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.header_mode(header_mode), .rom_type(rom_type), .rom_mask(rom_mask),
		.ram_mask(ram_mask), .rom_region(rom_region)
	);

	cheat_code_collector u_codes (
		.clk_sys(clk_sys), .reset(reset), .code_download(code_download),
		.cart_download(cart_download), .ioctl_wr(code_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .gg_code(gg_code), .gg_reset(gg_reset)
	);

	backup_ram u_bsram (
		.clk_sys(clk_sys), .cart_download(cart_download), .ioctl_wr(cart_wr),
		.ioctl_addr(ioctl_addr), .bsram_addr(bsram_addr), .bsram_d(bsram_d),
		.bsram_ce_n(bsram_ce_n), .bsram_we_n(bsram_we_n),
		.sd_lba_low(sd_lba[bsram_bits-sector_word_bits-2:0]), .sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr), .bsram_q(bsram_q), .sd_buff_din(sd_buff_din)
	);

	backup_sequencer u_backup (
		.clk_sys(clk_sys), .reset(reset), .cart_download(cart_download),
		.ram_mask(ram_mask), .img_mounted(img_mounted), .img_readonly(img_readonly),
		.img_size_nonzero(img_size_nonzero), .bk_load_req(bk_load_req),
		.bk_save_req(bk_save_req), .autosave(autosave), .osd_status(osd_status),
		.bsram_ce_n(bsram_ce_n), .bsram_we_n(bsram_we_n), .sd_ack(sd_ack),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .loading(loading),
		.pending(pending)
	);

endmodule

/* test/cart_loader_properties.sv */
// Bound assertions on the sector request protocol and the cheat code strobe
module cart_loader_properties (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd,
	input logic sd_wr,
	input logic sd_ack,
	input logic code_strobe
);
	timeunit 1ns;
	timeprecision 1ps;

	// One transfer direction at a time
	rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (!reset) !(sd_rd && sd_wr)
	) else $error("sd_rd and sd_wr are high together");

	// A new request only once the host has released ack
	request_after_ack: assert property (
		@(posedge clk_sys) disable iff (!reset) $rose(sd_rd || sd_wr) |-> !sd_ack
	) else $error("sector request raised while sd_ack is high");

	// Code words load on a single-cycle strobe
	strobe_single: assert property (
		@(posedge clk_sys) disable iff (!reset) code_strobe |=> !code_strobe
	) else $error("cheat code strobe lasted more than one cycle");

endmodule

bind backup_sequencer cart_loader_properties seq_props (
	.clk_sys(clk_sys), .reset(reset), .sd_rd(sd_rd), .sd_wr(sd_wr),
	.sd_ack(sd_ack), .code_strobe(1'b0)
);

bind cheat_code_collector cart_loader_properties code_props (
	.clk_sys(clk_sys), .reset(reset), .sd_rd(1'b0), .sd_wr(1'b0),
	.sd_ack(1'b0), .code_strobe(code_strobe)
);

/* test/cart_loader_tb.sv */
// Testbench for cart_loader_top with storage host model, LFSR stimulus and directed tests
module cart_loader_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cart_pkg::*;

	localparam int ram_bytes = 8192;
	localparam int image_words = ram_bytes / 2;
	localparam int ram_sectors = ram_bytes / 512;
	localparam int sector_cycles = 300;
	localparam int download_words = 512;
	// Two full transfers, core fill of the RAM, downloads and margin
	localparam int timeout_cycles = 2 * ram_sectors * sector_cycles + 2 * ram_bytes
		+ 2 * download_words + 5000;

	logic clk_sys;
	logic reset;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic ioctl_wr;
	logic [2:0] header_mode;
	logic autosave;
	logic bk_load_req;
	logic bk_save_req;
	logic osd_status;
	logic img_mounted;
	logic img_readonly;
	logic img_size_nonzero;
	logic sd_ack;
	logic [7:0] sd_buff_addr;
	logic [15:0] sd_buff_dout;
	logic sd_buff_wr;
	logic [19:0] bsram_addr;
	logic [7:0] bsram_d;
	logic bsram_ce_n;
	logic bsram_we_n;
	logic [7:0] rom_type;
	logic [23:0] rom_mask;
	logic [23:0] ram_mask;
	logic rom_region;
	logic [128:0] gg_code;
	logic gg_reset;
	logic [31:0] sd_lba;
	logic sd_rd;
	logic sd_wr;
	logic [15:0] sd_buff_din;
	logic [7:0] bsram_q;
	logic core_hold;
	logic led_user;

	logic [31:0] lfsr_state = 32'h671f_2ed8;
	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;
	int strobe_count = 0;
	int sector_count = 0;
	logic [7:0] exp_ram [0:ram_bytes-1];
	logic [15:0] save_img [0:image_words-1];
	logic [15:0] load_img [0:image_words-1];

	cart_loader_top dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Helpers
	// ============================================================

	// Taps 32, 22, 2, 1; one step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Size code n covers 1 KB << n bytes
	function automatic logic [23:0] mask_for_size(input logic [3:0] size);
		logic [63:0] span;
		span = (64'd1 << (int'(size) + 10)) - 64'd1;
		return span[23:0];
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic start_download(input logic [7:0] index, input logic [2:0] mode);
		@(posedge clk_sys);
		ioctl_index <= index;
		header_mode <= mode;
		ioctl_download <= 1'b1;
	endtask

	task automatic send_word(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr <= 1'b1;
	endtask

	// A few idle cycles let the masks and backup enable settle
	task automatic finish_download();
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		repeat (2) @(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic write_byte(input logic [19:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		bsram_addr <= addr;
		bsram_d <= data;
		bsram_ce_n <= 1'b0;
		bsram_we_n <= 1'b0;
	endtask

	task automatic release_core();
		@(posedge clk_sys);
		bsram_ce_n <= 1'b1;
		bsram_we_n <= 1'b1;
	endtask

	task automatic read_byte(input logic [19:0] addr, output logic [7:0] data);
		@(posedge clk_sys);
		bsram_addr <= addr;
		bsram_ce_n <= 1'b0;
		bsram_we_n <= 1'b1;
		@(posedge clk_sys);
		bsram_ce_n <= 1'b1;
		@(negedge clk_sys);
		data = bsram_q;
	endtask

	// Sector buffer data trails its address by two edges
	task automatic serve_sector(input logic is_load, input logic [31:0] lba);
		int base;
		base = int'(lba[7:0]) * 256;
		sd_ack <= 1'b1;
		for (int k = 0; k < 258; k++) begin
			@(posedge clk_sys);
			if (!is_load && k >= 2) begin
				save_img[base + k - 2] = sd_buff_din;
			end
			if (k < 256) begin
				sd_buff_addr <= k[7:0];
				sd_buff_wr <= is_load;
				sd_buff_dout <= load_img[base + k];
			end else begin
				sd_buff_wr <= 1'b0;
			end
		end
		sd_ack <= 1'b0;
		sector_count++;
	endtask

	// Storage host
	initial begin
		forever begin
			@(posedge clk_sys);
			if (sd_rd === 1'b1 || sd_wr === 1'b1) begin
				serve_sector(sd_rd === 1'b1, sd_lba);
			end
		end
	end

	always @(negedge clk_sys) begin
		if (gg_code[128] === 1'b1) begin
			strobe_count++;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ============================================================
	// Directed tests
	// ============================================================

	task automatic auto_header();
		logic [15:0] w0;
		logic [15:0] w2;
		logic [3:0] rom_sz;
		logic [3:0] ram_sz;
		for (int pass = 0; pass < 3; pass++) begin
			w0 = 16'(random_bits(16));
			w2 = 16'(random_bits(16));
			if (w0[7:0] != 8'd0) begin
				rom_sz = w0[3:0];
				ram_sz = w0[7:4];
			end else begin
				rom_sz = default_rom_size;
				ram_sz = 4'd0;
			end
			start_download(8'h00, hdr_auto);
			send_word(25'd0, w0);
			@(negedge clk_sys);
			check_value(gg_reset, 1'b1, "gg_reset during cartridge download");
			send_word(25'd2, w2);
			for (int i = 2; i < 16; i++) begin
				send_word(25'(2 * i), 16'(random_bits(16)));
			end
			finish_download();
			@(negedge clk_sys);
			check_value(rom_type, w0[15:8], "auto rom_type");
			check_value(rom_region, w2[8], "auto rom_region");
			check_value(rom_mask, mask_for_size(rom_sz), "auto rom_mask");
			check_value(ram_mask, (ram_sz != 0) ? mask_for_size(ram_sz) : 24'd0, "auto ram_mask");
		end
	endtask

	task automatic forced_mapping();
		logic [3:0] rom_sz;
		logic [3:0] ram_sz;
		logic [15:0] rom_word;
		logic [15:0] ram_word;
		// Below the default size code so the header value has to win
		rom_sz = 4'(random_bits(3));
		ram_sz = 4'(random_bits(4));
		if (ram_sz == 4'd0) begin
			ram_sz = 4'd1;
		end
		rom_word = 16'(random_bits(16));
		rom_word[11:8] = rom_sz;
		ram_word = 16'(random_bits(16));
		ram_word[3:0] = ram_sz;
		start_download(8'h00, hdr_lorom);
		send_word(25'd0, 16'(random_bits(16)));
		send_word(lorom_size_addr, rom_word);
		send_word(lorom_size_addr + 25'd2, ram_word);
		finish_download();
		@(negedge clk_sys);
		check_value(rom_type, 8'd0, "LoROM rom_type");
		check_value(rom_mask, mask_for_size(rom_sz), "LoROM rom_mask");
		check_value(ram_mask, mask_for_size(ram_sz), "LoROM ram_mask");

		// ExHiROM with no RAM
		rom_sz = 4'(random_bits(3));
		rom_word[11:8] = rom_sz;
		ram_word[3:0] = 4'd0;
		start_download(8'h00, hdr_exhirom);
		send_word(25'd0, 16'(random_bits(16)));
		send_word(exhirom_size_addr, rom_word);
		send_word(exhirom_size_addr + 25'd2, ram_word);
		finish_download();
		@(negedge clk_sys);
		check_value(rom_type, 8'd2, "ExHiROM rom_type");
		check_value(rom_mask, mask_for_size(rom_sz), "ExHiROM rom_mask");
		check_value(ram_mask, 24'd0, "ExHiROM ram_mask");
	endtask

	task automatic cheat_code();
		logic [15:0] w [0:7];
		strobe_count = 0;
		start_download(code_index, hdr_auto);
		// A code file written from address 0 flushes the code list
		send_word(25'd0, 16'(random_bits(16)));
		@(negedge clk_sys);
		check_value(gg_reset, 1'b1, "gg_reset on code write at address 0");
		for (int i = 0; i < 8; i++) begin
			w[i] = 16'(random_bits(16));
			send_word(copier_offset + 25'(2 * i), w[i]);
			@(negedge clk_sys);
			check_value(gg_reset, 1'b0, "gg_reset on code write past address 0");
		end
		finish_download();
		@(negedge clk_sys);
		check_value(gg_code[127:96], {w[1], w[0]}, "code flags");
		check_value(gg_code[95:64], {w[3], w[2]}, "code address");
		check_value(gg_code[63:32], {w[5], w[4]}, "code compare");
		check_value(gg_code[31:0], {w[7], w[6]}, "code replace");
		check_value(strobe_count, 1, "code strobe count");
	endtask

	task automatic save_ram_access();
		logic [19:0] addr;
		logic [7:0] data;
		logic [7:0] q;
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		img_readonly <= 1'b0;
		start_download(8'h00, hdr_auto);
		// 8 KB of RAM in the header
		send_word(25'd0, 16'h003B);
		for (int i = 1; i < download_words; i++) begin
			send_word(25'(2 * i), 16'(random_bits(16)));
		end
		finish_download();
		for (int i = 0; i < 16; i++) begin
			addr = 20'(random_bits(9)) << 1;
			read_byte(addr, q);
			check_value(q, addr[7:0], "cleared save RAM byte");
		end
		for (int i = 0; i < 16; i++) begin
			addr = 20'(random_bits(13));
			data = 8'(random_bits(8));
			write_byte(addr, data);
			read_byte(addr, q);
			check_value(q, data, "core read back");
		end
		@(negedge clk_sys);
		check_value(led_user, 1'b0, "led_user without autosave");
		@(posedge clk_sys);
		autosave <= 1'b1;
		@(negedge clk_sys);
		check_value(led_user, 1'b1, "led_user with autosave and pending writes");
		@(posedge clk_sys);
		autosave <= 1'b0;
	endtask

	task automatic sector_save();
		start_download(8'h00, hdr_auto);
		send_word(25'd0, 16'h003B);
		finish_download();
		for (int a = 0; a < ram_bytes; a++) begin
			exp_ram[a] = 8'(random_bits(8));
			write_byte(20'(a), exp_ram[a]);
		end
		release_core();
		@(negedge clk_sys);
		check_value(ram_mask, mask_for_size(4'd3), "8 KB ram_mask");
		sector_count = 0;
		@(posedge clk_sys);
		bk_save_req <= 1'b1;
		@(posedge clk_sys);
		bk_save_req <= 1'b0;
		@(negedge clk_sys);
		check_value(dut0.u_backup.busy, 1'b1, "save started");
		while (dut0.u_backup.busy) begin
			check_value(core_hold, 1'b0, "core_hold during save");
			@(negedge clk_sys);
		end
		check_value(sector_count, ram_sectors, "saved sector count");
		for (int i = 0; i < image_words; i++) begin
			check_value(save_img[i], {exp_ram[2 * i + 1], exp_ram[2 * i]}, "saved sector word");
		end
	endtask

	task automatic auto_load();
		logic [19:0] addr;
		logic [15:0] w;
		logic [7:0] q;
		for (int i = 0; i < image_words; i++) begin
			load_img[i] = 16'(random_bits(16));
		end
		sector_count = 0;
		@(posedge clk_sys);
		img_size_nonzero <= 1'b1;
		start_download(8'h00, hdr_auto);
		send_word(25'd0, 16'h003B);
		finish_download();
		@(negedge clk_sys);
		check_value(core_hold, 1'b1, "core_hold as autoload starts");
		while (core_hold) begin
			@(negedge clk_sys);
		end
		check_value(sector_count, ram_sectors, "sectors loaded when core_hold falls");
		@(posedge clk_sys);
		img_size_nonzero <= 1'b0;
		for (int i = 0; i < 32; i++) begin
			addr = 20'(random_bits(13));
			w = load_img[addr[12:1]];
			read_byte(addr, q);
			check_value(q, addr[0] ? w[15:8] : w[7:0], "loaded byte");
		end
	endtask

	initial begin
		reset = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		header_mode = hdr_auto;
		autosave = 1'b0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		osd_status = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nonzero = 1'b0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		bsram_addr = '0;
		bsram_d = '0;
		bsram_ce_n = 1'b1;
		bsram_we_n = 1'b1;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b1;
		@(posedge clk_sys);

		auto_header();
		forced_mapping();
		cheat_code();
		save_ram_access();
		sector_save();
		auto_load();

		repeat (4) @(posedge clk_sys);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* sources.f */
src/cart_pkg.sv
src/rom_header_detect.sv
src/cheat_code_collector.sv
src/backup_ram.sv
src/backup_sequencer.sv
src/cart_loader_top.sv
test/cart_loader_properties.sv
test/cart_loader_tb.sv
